/* vlog.f */
common/lc3b_types.sv
common/mem_bus_if.sv
cpu/regfile.sv
cpu/control_rom.sv
cpu/cpu_datapath.sv
rtl/mem_arbiter.sv
rtl/lc3b_core_top.sv
verif/mem_bus_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f vlog.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^Test completed successfully$"

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top import lc3b_types::*; ();

localparam lc3b_word START_PC = 16'h3000;
localparam lc3b_word HALT_BASE = 16'h3080;
localparam lc3b_word HALT_WORD = 16'h0FFF;

logic clk = 1'b0;
logic arst_n;
lc3b_word pmem_address, pmem_wdata, pmem_rdata;
logic pmem_stb, pmem_cyc, pmem_write, pmem_resp, pmem_retry;
lc3b_mem_wmask pmem_byte_enable;

lc3b_word mem [32768];
lc3b_word ref_mem [32768];
lc3b_word exp_addr [$];
lc3b_word exp_data [$];
lc3b_word model_halt, halt_addr, first_addr;
int errors = 0;
int stores = 0;
int halt_hits [4];
logic halted = 1'b0;
logic seen_first = 1'b0;
logic busy = 1'b0;
int lat;

always #5 clk = ~clk;

lc3b_core_top #(
	.RESET_PC(START_PC)
) dut_i (
	.clk(clk),
	.arst_n(arst_n),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata),
	.pmem_stb(pmem_stb),
	.pmem_cyc(pmem_cyc),
	.pmem_write(pmem_write),
	.pmem_byte_enable(pmem_byte_enable),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp),
	.pmem_retry(pmem_retry)
);

function automatic lc3b_word sext(input lc3b_word v, input int bits);
	lc3b_word mask;
	mask = 16'hFFFF << bits;
	return v[bits-1] ? (v | mask) : (v & ~mask);
endfunction

function automatic logic [2:0] cc_of(input lc3b_word v);
	if (v[15])
		return 3'b100;
	return (v == 16'h0000) ? 3'b010 : 3'b001;
endfunction

function automatic lc3b_reg pick_dest();
	lc3b_reg d;
	d = 3'($urandom % 7);
	// r6 holds the data base.
	return (d == 3'd6) ? 3'd7 : d;
endfunction

// ****************************************
// program generator and isa model
// ****************************************
task automatic build_program();
	lc3b_word w;
	int i;
	for (i = 0; i < 32768; i++)
		mem[i] = 16'($urandom);
	mem[START_PC[15:1]] = {4'b1110, 3'd6, 9'd200};
	for (i = 1; i < 64; i++) begin
		case ($urandom % 7)
			0: w = {4'b0001, pick_dest(), 3'($urandom), 3'b000, 3'($urandom)};
			1: w = {4'b0001, pick_dest(), 3'($urandom), 1'b1, 5'($urandom)};
			2: w = {4'b0101, pick_dest(), 3'($urandom), ($urandom % 2 == 1) ?
				{1'b1, 5'($urandom)} : {3'b000, 3'($urandom)}};
			3: w = {4'b1001, pick_dest(), 3'($urandom), 6'b111111};
			4: w = {4'b0000, 3'($urandom), 9'(1 + $urandom % 3)};
			5: w = {4'b0110, pick_dest(), 3'd6, 6'(($urandom % 32) - 16)};
			default: w = {4'b0111, 3'($urandom), 3'd6, 6'(($urandom % 32) - 16)};
		endcase
		mem[START_PC[15:1] + 15'(i)] = w;
	end
	for (i = 0; i < 4; i++)
		mem[HALT_BASE[15:1] + 15'(i)] = HALT_WORD;
	ref_mem = mem;
endtask

task automatic run_model();
	lc3b_word r [8];
	lc3b_word pc, ir, a, b, res;
	logic [2:0] cc;
	int steps;
	for (int k = 0; k < 8; k++)
		r[k] = 16'h0000;
	pc = START_PC;
	cc = 3'b010;
	steps = 0;
	while (ref_mem[pc[15:1]] != HALT_WORD && steps < 1000) begin
		ir = ref_mem[pc[15:1]];
		a = r[ir[8:6]];
		b = ir[5] ? sext({11'b0, ir[4:0]}, 5) : r[ir[2:0]];
		steps++;
		case (ir[15:12])
			4'b0001, 4'b0101, 4'b1001: begin
				if (ir[15:12] == 4'b0001)
					res = a + b;
				else if (ir[15:12] == 4'b0101)
					res = a & b;
				else
					res = ~a;
				r[ir[11:9]] = res;
				cc = cc_of(res);
			end
			4'b1110: r[ir[11:9]] = pc + 16'd2 + (sext({7'b0, ir[8:0]}, 9) << 1);
			4'b0110: begin
				res = ref_mem[15'((a + (sext({10'b0, ir[5:0]}, 6) << 1)) >> 1)];
				r[ir[11:9]] = res;
				cc = cc_of(res);
			end
			4'b0111: begin
				res = a + (sext({10'b0, ir[5:0]}, 6) << 1);
				ref_mem[res[15:1]] = r[ir[11:9]];
				exp_addr.push_back(res);
				exp_data.push_back(r[ir[11:9]]);
			end
			default: ;
		endcase
		if (ir[15:12] == 4'b0000 && (ir[11:9] & cc) != 3'b000)
			pc = pc + 16'd2 + (sext({7'b0, ir[8:0]}, 9) << 1);
		else
			pc = pc + 16'd2;
	end
	model_halt = pc;
endtask

// ****************************************
// memory model on the pmem port
// ****************************************
task automatic check_store();
	lc3b_word ea, ed;
	stores++;
	if (pmem_byte_enable != 2'b11) begin
		$display("MISMATCH pmem_byte_enable got %h expected %h", pmem_byte_enable, 2'b11);
		errors++;
	end
	if (exp_addr.size() == 0) begin
		$display("store to %h not expected by the model", pmem_address);
		errors++;
	end else begin
		ea = exp_addr.pop_front();
		ed = exp_data.pop_front();
		if (pmem_address != ea) begin
			$display("MISMATCH pmem_address got %h expected %h", pmem_address, ea);
			errors++;
		end
		if (pmem_wdata != ed) begin
			$display("MISMATCH pmem_wdata got %h expected %h", pmem_wdata, ed);
			errors++;
		end
	end
endtask

task automatic serve_request();
	int slot;
	if (pmem_write) begin
		check_store();
		mem[pmem_address[15:1]] = pmem_wdata;
	end else begin
		pmem_rdata = mem[pmem_address[15:1]];
		if (pmem_address >= HALT_BASE && pmem_address < HALT_BASE + 16'd8) begin
			slot = int'((pmem_address - HALT_BASE) >> 1);
			halt_hits[slot]++;
			if (halt_hits[slot] >= 4 && !halted) begin
				halted = 1'b1;
				halt_addr = pmem_address;
			end
		end
	end
endtask

always @(negedge clk) begin
	if (!arst_n) begin
		busy = 1'b0;
		pmem_resp = 1'b0;
		pmem_retry = 1'b0;
	end else begin
		pmem_resp = 1'b0;
		pmem_retry = 1'b0;
		if (!busy && pmem_stb) begin
			busy = 1'b1;
			lat = int'($urandom % 4);
			if (!seen_first) begin
				seen_first = 1'b1;
				first_addr = pmem_address;
			end
		end
		if (busy) begin
			if (lat != 0) begin
				lat--;
			end else begin
				busy = 1'b0;
				if ($urandom % 8 == 0) begin
					pmem_retry = 1'b1;
				end else begin
					pmem_resp = 1'b1;
					serve_request();
				end
			end
		end
	end
end

// ****************************************
// main sequence
// ****************************************
initial begin
	int n;
	arst_n = 1'b0;
	pmem_rdata = 16'h0000;
	pmem_resp = 1'b0;
	pmem_retry = 1'b0;
	void'($urandom(32'h1726_2f44));
	build_program();
	run_model();
	for (n = 0; n < 3; n++) begin
		@(negedge clk);
		if (pmem_stb || pmem_cyc || pmem_write) begin
			$display("port active during reset");
			errors++;
		end
	end
	arst_n = 1'b1;
	for (n = 0; n < 50 && !seen_first; n++)
		@(negedge clk);
	if (!seen_first) begin
		$display("no request seen after reset");
		errors++;
	end else if (first_addr != START_PC) begin
		$display("MISMATCH pmem_address got %h expected %h", first_addr, START_PC);
		errors++;
	end
	for (n = 0; n < 20000 && !halted; n++)
		@(negedge clk);
	if (!halted) begin
		$display("program did not reach its halt loop in time");
		errors++;
	end else begin
		if (halt_addr != model_halt) begin
			$display("MISMATCH halt address got %h expected %h", halt_addr, model_halt);
			errors++;
		end
		if (exp_addr.size() != 0) begin
			$display("%0d expected stores never appeared", exp_addr.size());
			errors++;
		end
	end
	$display("stores seen %0d, errors %0d", stores, errors);
	if (errors == 0)
		$display("Test completed successfully");
	else
		$display("Test failed");
	$finish;
end

endmodule : tb_top

/* verif/mem_bus_checker.sv */
`timescale 1ns/1ps

module mem_bus_checker import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_word pmem_address,
	input lc3b_word pmem_wdata,
	input logic pmem_stb,
	input logic pmem_cyc,
	input logic pmem_write,
	input logic pmem_resp,
	input logic pmem_retry
);

stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n)
	pmem_stb |-> pmem_cyc)
	else $error("stb high without cyc");

// request fields frozen until the slave answers.
request_stable: assert property (@(posedge clk) disable iff (!arst_n)
	(pmem_cyc && !pmem_resp && !pmem_retry) |=>
	($stable(pmem_address) && $stable(pmem_wdata) && $stable(pmem_write)))
	else $error("request changed before resp or retry");

// the retried master backs off; only the other master may show up.
retry_backoff: assert property (@(posedge clk) disable iff (!arst_n)
	pmem_retry |=> (!pmem_stb || pmem_address != $past(pmem_address)))
	else $error("stb not dropped after retry");

endmodule : mem_bus_checker

bind lc3b_core_top mem_bus_checker chk_i (
	.clk(clk),
	.arst_n(arst_n),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata),
	.pmem_stb(pmem_stb),
	.pmem_cyc(pmem_cyc),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.pmem_retry(pmem_retry)
);

/* rtl/lc3b_core_top.sv */
`timescale 1ns/1ps

module lc3b_core_top import lc3b_types::*; #(
	parameter lc3b_word RESET_PC = 16'h3000
) (
	input logic clk,
	input logic arst_n,
	output lc3b_word pmem_address,
	output lc3b_word pmem_wdata,
	output logic pmem_stb,
	output logic pmem_cyc,
	output logic pmem_write,
	output lc3b_mem_wmask pmem_byte_enable,
	input lc3b_word pmem_rdata,
	input logic pmem_resp,
	input logic pmem_retry
);

mem_bus_if imem_bus ();
mem_bus_if dmem_bus ();

cpu_datapath #(
	.RESET_PC(RESET_PC)
) datapath (
	.clk(clk),
	.arst_n(arst_n),
	.imem_bus(imem_bus.master),
	.dmem_bus(dmem_bus.master)
);

mem_arbiter arbiter (
	.clk(clk),
	.arst_n(arst_n),
	.imem_bus(imem_bus.slave),
	.dmem_bus(dmem_bus.slave),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata),
	.pmem_stb(pmem_stb),
	.pmem_cyc(pmem_cyc),
	.pmem_write(pmem_write),
	.pmem_byte_enable(pmem_byte_enable),
	.pmem_rdata(pmem_rdata),
	.pmem_resp(pmem_resp),
	.pmem_retry(pmem_retry)
);

endmodule : lc3b_core_top

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	mem_bus_if.slave imem_bus,
	mem_bus_if.slave dmem_bus,
	output lc3b_word pmem_address,
	output lc3b_word pmem_wdata,
	output logic pmem_stb,
	output logic pmem_cyc,
	output logic pmem_write,
	output lc3b_mem_wmask pmem_byte_enable,
	input lc3b_word pmem_rdata,
	input logic pmem_resp,
	input logic pmem_retry
);

typedef enum logic [1:0] {grant_idle, grant_inst, grant_data} grant_t;

grant_t grant_q;
grant_t sel;
logic use_data;

// data side wins a tie when idle.
always_comb begin
	if (grant_q != grant_idle)
		sel = grant_q;
	else if (dmem_bus.cyc)
		sel = grant_data;
	else
		sel = grant_inst;
end

assign use_data = (sel == grant_data);

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		grant_q <= grant_idle;
	else if (pmem_resp || pmem_retry)
		grant_q <= grant_idle;
	else if (grant_q == grant_idle && (imem_bus.cyc || dmem_bus.cyc))
		grant_q <= sel;
end

assign pmem_address = use_data ? dmem_bus.address : imem_bus.address;
assign pmem_wdata = use_data ? dmem_bus.wdata : imem_bus.wdata;
assign pmem_stb = use_data ? dmem_bus.stb : imem_bus.stb;
assign pmem_cyc = use_data ? dmem_bus.cyc : imem_bus.cyc;
assign pmem_write = use_data ? dmem_bus.write : imem_bus.write;
assign pmem_byte_enable = use_data ? dmem_bus.byte_enable : imem_bus.byte_enable;

// losing master sees nothing and keeps waiting.
assign imem_bus.rdata = pmem_rdata;
assign imem_bus.resp = pmem_resp && !use_data;
assign imem_bus.retry = pmem_retry && !use_data;
assign dmem_bus.rdata = pmem_rdata;
assign dmem_bus.resp = pmem_resp && use_data;
assign dmem_bus.retry = pmem_retry && use_data;

endmodule : mem_arbiter

/* cpu/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath import lc3b_types::*; #(
	parameter lc3b_word RESET_PC = 16'h3000
) (
	input logic clk,
	input logic arst_n,
	mem_bus_if.master imem_bus,
	mem_bus_if.master dmem_bus
);

typedef enum logic [1:0] {s_fetch, s_execute, s_memory, s_writeback} state_t;

state_t state;
lc3b_control_word ctrl;
lc3b_word pc, pc_plus2, pc_target, fetch_pc, if_addr, pf_buf, ir, mdr;
lc3b_word dm_addr, dm_wdata, mem_addr;
lc3b_word reg_a, reg_b, imm5, off6, off9, alu_b, alu_out, rf_in;
logic pf_valid, if_cyc, if_gap, if_discard;
logic consume, flush, if_start, br_taken;
logic dm_cyc, dm_gap, dm_write, rf_load;
logic [2:0] cc, next_cc;

control_rom decode (
	.instruction(ir),
	.ctrl(ctrl)
);

regfile regs (
	.clk(clk),
	.arst_n(arst_n),
	.load(rf_load),
	.dest(ctrl.dest_register),
	.in_data(rf_in),
	.src_a(ctrl.sr1),
	.src_b(ctrl.sr2),
	.reg_a(reg_a),
	.reg_b(reg_b)
);

// ****************************************
// operands and alu
// ****************************************
assign imm5 = {{11{ir[4]}}, ir[4:0]};
assign off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
assign off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
assign pc_plus2 = pc + 16'd2;
assign pc_target = pc_plus2 + off9;
assign mem_addr = reg_a + off6;

always_comb begin
	alu_b = ctrl.use_imm5 ? imm5 : reg_b;
	case (ctrl.aluop)
		alu_add: alu_out = reg_a + alu_b;
		alu_and: alu_out = reg_a & alu_b;
		alu_not: alu_out = ~reg_a;
		alu_pass: alu_out = pc_target;
	endcase
end

// loads write back one cycle after their resp.
assign rf_in = (state == s_writeback) ? mdr : alu_out;
assign rf_load = (state == s_execute && ctrl.load_regfile && !ctrl.mem_read) ||
	(state == s_writeback);
assign next_cc = rf_in[15] ? 3'b100 : ((rf_in == 16'h0000) ? 3'b010 : 3'b001);
assign br_taken = ctrl.is_branch && |(ir[11:9] & cc);

// ****************************************
// instruction fetch and prefetch buffer
// ****************************************
assign consume = (state == s_fetch) && pf_valid;
assign flush = (state == s_execute) && br_taken;
// next fetch starts as the buffered word moves to ir.
assign if_start = !if_cyc && !if_gap && (!pf_valid || consume) && !flush;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		if_cyc <= 1'b0;
		if_gap <= 1'b0;
		if_discard <= 1'b0;
		pf_valid <= 1'b0;
		fetch_pc <= RESET_PC;
	end else begin
		if_gap <= 1'b0;
		if (if_cyc) begin
			if (imem_bus.resp) begin
				if_cyc <= 1'b0;
				if_discard <= 1'b0;
				if (!if_discard && !flush) begin
					pf_valid <= 1'b1;
					fetch_pc <= fetch_pc + 16'd2;
				end
			end else if (imem_bus.retry) begin
				if_cyc <= 1'b0;
				if_gap <= 1'b1;
				if_discard <= 1'b0;
			end
		end else if (if_start) begin
			if_cyc <= 1'b1;
		end
		if (consume)
			pf_valid <= 1'b0;
		// taken branch redirects fetch. an open request still ends but is dropped.
		if (flush) begin
			pf_valid <= 1'b0;
			fetch_pc <= pc_target;
			if (if_cyc && !imem_bus.resp && !imem_bus.retry)
				if_discard <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (if_start)
		if_addr <= fetch_pc;
	if (if_cyc && imem_bus.resp)
		pf_buf <= imem_bus.rdata;
	if (consume)
		ir <= pf_buf;
	if (state == s_execute) begin
		dm_addr <= mem_addr;
		dm_wdata <= reg_b;
	end
	if (state == s_memory && dmem_bus.resp)
		mdr <= dmem_bus.rdata;
end

// ****************************************
// sequencer
// ****************************************
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= s_fetch;
		pc <= RESET_PC;
		cc <= 3'b010;
		dm_cyc <= 1'b0;
		dm_gap <= 1'b0;
		dm_write <= 1'b0;
	end else begin
		if (rf_load && ctrl.load_cc)
			cc <= next_cc;
		case (state)
			s_fetch: begin
				if (pf_valid)
					state <= s_execute;
			end
			s_execute: begin
				if (ctrl.mem_read || ctrl.mem_write) begin
					dm_cyc <= 1'b1;
					dm_write <= ctrl.mem_write;
					state <= s_memory;
				end else begin
					pc <= br_taken ? pc_target : pc_plus2;
					state <= s_fetch;
				end
			end
			s_memory: begin
				if (dm_gap) begin
					dm_gap <= 1'b0;
					dm_cyc <= 1'b1;
				end else if (dmem_bus.resp) begin
					dm_cyc <= 1'b0;
					dm_write <= 1'b0;
					if (dm_write) begin
						pc <= pc_plus2;
						state <= s_fetch;
					end else begin
						state <= s_writeback;
					end
				end else if (dmem_bus.retry) begin
					// one idle cycle, then the same request again.
					dm_cyc <= 1'b0;
					dm_gap <= 1'b1;
				end
			end
			s_writeback: begin
				pc <= pc_plus2;
				state <= s_fetch;
			end
		endcase
	end
end

assign imem_bus.address = if_addr;
assign imem_bus.wdata = 16'h0000;
assign imem_bus.stb = if_cyc;
assign imem_bus.cyc = if_cyc;
assign imem_bus.write = 1'b0;
assign imem_bus.byte_enable = 2'b11;

assign dmem_bus.address = dm_addr;
assign dmem_bus.wdata = dm_wdata;
assign dmem_bus.stb = dm_cyc;
assign dmem_bus.cyc = dm_cyc;
assign dmem_bus.write = dm_write;
assign dmem_bus.byte_enable = 2'b11;

endmodule : cpu_datapath

/* cpu/control_rom.sv */
`timescale 1ns/1ps

module control_rom import lc3b_types::*; (
	input lc3b_word instruction,
	output lc3b_control_word ctrl
);

lc3b_opcode opcode;

assign opcode = lc3b_opcode'(instruction[15:12]);

always_comb begin
	ctrl = '0;
	ctrl.opcode = opcode;
	ctrl.aluop = alu_pass;
	ctrl.dest_register = instruction[11:9];
	ctrl.sr1 = instruction[8:6];
	ctrl.sr2 = instruction[2:0];
	case (opcode)
		op_add: begin
			ctrl.aluop = alu_add;
			ctrl.use_imm5 = instruction[5];
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_and: begin
			ctrl.aluop = alu_and;
			ctrl.use_imm5 = instruction[5];
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_not: begin
			ctrl.aluop = alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_br: ctrl.is_branch = 1'b1;
		// lea leaves the condition codes alone.
		op_lea: ctrl.load_regfile = 1'b1;
		op_ldr: begin
			ctrl.mem_read = 1'b1;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_str: begin
			ctrl.mem_write = 1'b1;
			ctrl.sr2 = instruction[11:9];
		end
		default: ;
	endcase
end

endmodule : control_rom

/* cpu/regfile.sv */
`timescale 1ns/1ps

module regfile import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_reg dest,
	input lc3b_word in_data,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

lc3b_word data [8];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < 8; i++)
			data[i] <= 16'h0000;
	end else if (load) begin
		data[dest] <= in_data;
	end
end

// read ports see the old value during a write.
assign reg_a = data[src_a];
assign reg_b = data[src_b];

endmodule : regfile

/* common/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if import lc3b_types::*; ();

	lc3b_word address;
	lc3b_word wdata;
	logic stb;
	logic cyc;
	logic write;
	lc3b_mem_wmask byte_enable;

	lc3b_word rdata;
	logic resp;
	logic retry;

	// request side, held until resp or retry.
	modport master (
		output address, wdata, stb, cyc, write, byte_enable,
		input rdata, resp, retry
	);

	modport slave (
		input address, wdata, stb, cyc, write, byte_enable,
		output rdata, resp, retry
	);

endinterface : mem_bus_if

/* common/lc3b_types.sv */
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [1:0] lc3b_mem_wmask;

// standard LC-3b opcode field values.
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001,
	op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic use_imm5;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic is_branch;
	lc3b_reg dest_register;
	lc3b_reg sr1;
	lc3b_reg sr2;
} lc3b_control_word;

endpackage : lc3b_types
